// ==== include/riscvControl_macros.svh ====
`ifndef RISCVCONTROL_MACROS_SVH
`define RISCVCONTROL_MACROS_SVH

// data word width, also the instruction and immediate width
`define XLEN 32

// memory access control code width
`define MEM_CONTROL_WIDTH 4

// alu operation code width
`define ALU_OP_WIDTH 4

`endif

// ==== src/InstrFormatPkg.sv ====
package InstrFormatPkg;

  // rv32i major opcodes, low two bits are always 2'b11
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_BRANCH = 7'b1100011,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111,
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111
  } OpcodeT;

  // register-register format
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    OpcodeT     opcode;
  } RTypeT;

  // immediate, loads and jalr
  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    OpcodeT      opcode;
  } ITypeT;

  // store, immediate split around rs2/rs1
  typedef struct packed {
    logic [6:0] immHigh;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] immLow;
    OpcodeT     opcode;
  } STypeT;

  // branch, bit 11 parked where rd would be
  typedef struct packed {
    logic       immBit12;
    logic [5:0] immHigh;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] immLow;
    logic       immBit11;
    OpcodeT     opcode;
  } BTypeT;

  // lui / auipc
  typedef struct packed {
    logic [19:0] imm;
    logic [4:0]  rd;
    OpcodeT      opcode;
  } UTypeT;

  // jal, scrambled 20-bit offset
  typedef struct packed {
    logic       immBit20;
    logic [9:0] immLow;
    logic       immBit11;
    logic [7:0] immHigh;
    logic [4:0] rd;
    OpcodeT     opcode;
  } JTypeT;

  // one 32-bit word, six ways to read it
  typedef union packed {
    RTypeT rType;
    ITypeT iType;
    STypeT sType;
    BTypeT bType;
    UTypeT uType;
    JTypeT jType;
  } InstrWordU;

endpackage

// ==== src/ControlTypesPkg.sv ====
`include "riscvControl_macros.svh"

package ControlTypesPkg;

  // coarse instruction class
  typedef enum logic [2:0] {
    REG_COMMPUTATION,
    IMM_COMPUTATION,
    LOAD,
    STORE,
    UPPER,
    JUMP,
    BRANCH,
    NONE
  } InstructionTypes;

  // refinement within a class, NO_SUBTYPE for computations
  typedef enum logic [4:0] {
    NO_SUBTYPE,
    LOAD_WORD, LOAD_HALF, LOAD_BYTE, ULOAD_HALF, ULOAD_BYTE,
    STORE_WORD, STORE_HALF, STORE_BYTE,
    BEQ, BNE, BLT, BGE, BLTU, BGEU,
    LOAD_UPPER_IMM, ADD_UPPER_PC,
    JAL_LINK, JALR_LINK
  } InstructionSubTypes;

  // memory access control, codes fixed by the memory side
  typedef enum logic [`MEM_CONTROL_WIDTH-1:0] {
    MEM_LW   = 4'd0,
    MEM_LH   = 4'd1,
    MEM_LB   = 4'd2,
    MEM_LHU  = 4'd3,
    MEM_LBU  = 4'd4,
    MEM_SW   = 4'd5,
    MEM_SH   = 4'd6,
    MEM_SB   = 4'd7,
    MEM_NONE = 4'd8
  } MemControlT;

  // alu operation
  typedef enum logic [`ALU_OP_WIDTH-1:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
    ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASSB
  } AluOpT;

endpackage

// ==== src/InstructionClassifier.sv ====
`timescale 1ns/1ps

module InstructionClassifier
  import InstrFormatPkg::*;
  import ControlTypesPkg::*;
(
  input  InstrWordU          instr,
  output InstructionTypes    instrType,
  output InstructionSubTypes instrSubType,
  output logic               illegal
);

  always_comb begin
    instrType    = NONE;
    instrSubType = NO_SUBTYPE;
    illegal      = 1'b0;

    // opcode sits at the same place in every view
    case (instr.rType.opcode)
      OPC_OP:     instrType = REG_COMMPUTATION;
      OPC_OP_IMM: instrType = IMM_COMPUTATION;

      OPC_LOAD: begin
        instrType = LOAD;
        case (instr.iType.funct3)
          3'b000:  instrSubType = LOAD_BYTE;
          3'b001:  instrSubType = LOAD_HALF;
          3'b010:  instrSubType = LOAD_WORD;
          3'b100:  instrSubType = ULOAD_BYTE;
          3'b101:  instrSubType = ULOAD_HALF;
          // 011, 110, 111 reserved in rv32i
          default: illegal = 1'b1;
        endcase
      end

      OPC_STORE: begin
        instrType = STORE;
        case (instr.sType.funct3)
          3'b000:  instrSubType = STORE_BYTE;
          3'b001:  instrSubType = STORE_HALF;
          3'b010:  instrSubType = STORE_WORD;
          default: illegal = 1'b1;
        endcase
      end

      OPC_BRANCH: begin
        instrType = BRANCH;
        case (instr.bType.funct3)
          3'b000:  instrSubType = BEQ;
          3'b001:  instrSubType = BNE;
          3'b100:  instrSubType = BLT;
          3'b101:  instrSubType = BGE;
          3'b110:  instrSubType = BLTU;
          3'b111:  instrSubType = BGEU;
          // 010 and 011 unused
          default: illegal = 1'b1;
        endcase
      end

      OPC_JAL: begin
        instrType    = JUMP;
        instrSubType = JAL_LINK;
      end

      OPC_JALR: begin
        instrType    = JUMP;
        instrSubType = JALR_LINK;
        // jalr only defined with funct3 zero
        if (instr.iType.funct3 != 3'b000) begin
          illegal = 1'b1;
        end
      end

      OPC_LUI: begin
        instrType    = UPPER;
        instrSubType = LOAD_UPPER_IMM;
      end

      OPC_AUIPC: begin
        instrType    = UPPER;
        instrSubType = ADD_UPPER_PC;
      end

      // csr, fence, system and garbage land here
      default: illegal = 1'b1;
    endcase

    // an illegal word carries no class downstream
    if (illegal) begin
      instrType    = NONE;
      instrSubType = NO_SUBTYPE;
    end
  end

  always_comb begin
    illegalHasNoType: assert final (!illegal || instrType == NONE)
      else $error("illegal word classified as %s", instrType.name());
  end

endmodule

// ==== src/ControlDecode.sv ====
`timescale 1ns/1ps

module ControlDecode
  import ControlTypesPkg::*;
(
  input  InstructionTypes    instrType,
  input  InstructionSubTypes instrSubType,
  input  logic               zero,
  output MemControlT         memControl,
  output logic               resultSrc,
  output logic               pcSrc,
  output logic               aluSrc,
  output logic               regWrite,
  output logic               memWrite
);

  // datapath controls from type, subtype refines upper and branch
  always_comb begin
    regWrite  = 1'b0;
    aluSrc    = 1'b0;
    pcSrc     = 1'b0;
    resultSrc = 1'b0;
    memWrite  = 1'b0;

    case (instrType)
      REG_COMMPUTATION: regWrite = 1'b1;

      IMM_COMPUTATION: begin
        regWrite = 1'b1;
        aluSrc   = 1'b1;
      end

      // address is rs1 + imm
      LOAD: begin
        regWrite = 1'b1;
        aluSrc   = 1'b1;
      end

      STORE: begin
        memWrite = 1'b1;
        aluSrc   = 1'b1;
      end

      UPPER: begin
        regWrite = 1'b1;
        if (instrSubType == LOAD_UPPER_IMM) begin
          aluSrc = 1'b1;
        end else begin
          // auipc result comes from the pc adder, pc still steps by 4
          resultSrc = 1'b1;
        end
      end

      // link value pc+4 goes to rd, target uses the immediate
      JUMP: begin
        pcSrc     = 1'b1;
        regWrite  = 1'b1;
        resultSrc = 1'b1;
        aluSrc    = 1'b1;
      end

      BRANCH: begin
        case (instrSubType)
          // zero high means rs1 == rs2
          BEQ:     pcSrc = zero;
          BNE:     pcSrc = ~zero;
          // ordered compares not resolved here
          default: pcSrc = 1'b0;
        endcase
      end

      default: ;
    endcase
  end

  // memory access width and sign
  always_comb begin
    case (instrSubType)
      LOAD_WORD:  memControl = MEM_LW;
      LOAD_HALF:  memControl = MEM_LH;
      LOAD_BYTE:  memControl = MEM_LB;
      ULOAD_HALF: memControl = MEM_LHU;
      ULOAD_BYTE: memControl = MEM_LBU;
      STORE_WORD: memControl = MEM_SW;
      STORE_HALF: memControl = MEM_SH;
      STORE_BYTE: memControl = MEM_SB;
      default:    memControl = MEM_NONE;
    endcase
  end

  always_comb begin
    singleWriter: assert final (!(regWrite && memWrite))
      else $error("regWrite and memWrite both high");
    storeHasStoreCode: assert final
      (!memWrite || memControl inside {MEM_SW, MEM_SH, MEM_SB})
      else $error("memWrite with memControl %s", memControl.name());
  end

endmodule

// ==== src/AluControlDecode.sv ====
`timescale 1ns/1ps

module AluControlDecode
  import InstrFormatPkg::*;
  import ControlTypesPkg::*;
(
  input  InstructionTypes instrType,
  input  InstrWordU       instr,
  output AluOpT           aluOp
);

  logic bit30;
  logic isRegOp;

  // funct7[5] is instruction bit 30
  assign bit30   = instr.rType.funct7[5];
  assign isRegOp = (instrType == REG_COMMPUTATION);

  always_comb begin
    // loads, stores, jumps and auipc all add
    aluOp = ALU_ADD;

    case (instrType)
      REG_COMMPUTATION, IMM_COMPUTATION: begin
        case (instr.rType.funct3)
          // addi has no sub form, bit 30 is immediate there
          3'b000:  aluOp = (isRegOp && bit30) ? ALU_SUB : ALU_ADD;
          3'b001:  aluOp = ALU_SLL;
          3'b010:  aluOp = ALU_SLT;
          3'b011:  aluOp = ALU_SLTU;
          3'b100:  aluOp = ALU_XOR;
          // shifts keep bit 30 in both forms
          3'b101:  aluOp = bit30 ? ALU_SRA : ALU_SRL;
          3'b110:  aluOp = ALU_OR;
          default: aluOp = ALU_AND;
        endcase
      end

      // subtract drives the zero flag for beq/bne
      BRANCH: aluOp = ALU_SUB;

      UPPER: begin
        if (instr.uType.opcode == OPC_LUI) begin
          aluOp = ALU_PASSB;
        end
      end

      default: ;
    endcase
  end

endmodule

// ==== src/ImmediateGenerator.sv ====
`timescale 1ns/1ps
`include "riscvControl_macros.svh"

module ImmediateGenerator
  import InstrFormatPkg::*;
(
  input  InstrWordU          instr,
  output logic [`XLEN-1:0]   imm
);

  always_comb begin
    case (instr.rType.opcode)
      // i format, 12 bits
      OPC_OP_IMM, OPC_LOAD, OPC_JALR:
        imm = {{(`XLEN-12){instr.iType.imm[11]}}, instr.iType.imm};

      OPC_STORE:
        imm = {{(`XLEN-12){instr.sType.immHigh[6]}},
               instr.sType.immHigh, instr.sType.immLow};

      // branch offset, halfword aligned
      OPC_BRANCH:
        imm = {{(`XLEN-13){instr.bType.immBit12}}, instr.bType.immBit12,
               instr.bType.immBit11, instr.bType.immHigh,
               instr.bType.immLow, 1'b0};

      // upper 20 bits, low 12 zero
      OPC_LUI, OPC_AUIPC:
        imm = {instr.uType.imm, 12'b0};

      OPC_JAL:
        imm = {{(`XLEN-21){instr.jType.immBit20}}, instr.jType.immBit20,
               instr.jType.immHigh, instr.jType.immBit11,
               instr.jType.immLow, 1'b0};

      // r format and unknown opcodes
      default: imm = '0;
    endcase
  end

endmodule

// ==== src/DecodeExecuteRegister.sv ====
`timescale 1ns/1ps
`include "riscvControl_macros.svh"

module DecodeExecuteRegister
  import ControlTypesPkg::*;
(
  input  logic               clk,
  input  logic               rst,
  input  logic               instrValid,
  input  logic               illegal,
  input  MemControlT         memControl,
  input  logic               resultSrc,
  input  logic               pcSrc,
  input  logic               aluSrc,
  input  logic               regWrite,
  input  logic               memWrite,
  input  AluOpT              aluOp,
  input  logic [`XLEN-1:0]   imm,
  output logic               exValid,
  output logic               exIllegal,
  output MemControlT         exMemControl,
  output logic               exResultSrc,
  output logic               exPcSrc,
  output logic               exAluSrc,
  output logic               exRegWrite,
  output logic               exMemWrite,
  output AluOpT              exAluOp,
  output logic [`XLEN-1:0]   exImm
);

  logic squash;
  logic accept;

  // stage holds a taken branch or jump so the incoming word is wrong path
  assign squash = exValid && exPcSrc;
  assign accept = instrValid && !illegal && !squash;

  always_ff @(posedge clk) begin
    if (rst) begin
      exValid      <= 1'b0;
      exIllegal    <= 1'b0;
      exMemControl <= MEM_NONE;
      exResultSrc  <= 1'b0;
      exPcSrc      <= 1'b0;
      exAluSrc     <= 1'b0;
      exRegWrite   <= 1'b0;
      exMemWrite   <= 1'b0;
    end else begin
      exValid <= accept;
      // only a real, non-squashed word can trap
      exIllegal <= instrValid && illegal && !squash;
      if (accept) begin
        exMemControl <= memControl;
        exResultSrc  <= resultSrc;
        exPcSrc      <= pcSrc;
        exAluSrc     <= aluSrc;
        exRegWrite   <= regWrite;
        exMemWrite   <= memWrite;
      end else begin
        // bubble
        exMemControl <= MEM_NONE;
        exResultSrc  <= 1'b0;
        exPcSrc      <= 1'b0;
        exAluSrc     <= 1'b0;
        exRegWrite   <= 1'b0;
        exMemWrite   <= 1'b0;
      end
    end
  end

  // operands follow the input every cycle
  always_ff @(posedge clk) begin
    exAluOp <= aluOp;
    exImm   <= imm;
  end

  bubbleIsQuiet: assert property (@(posedge clk) disable iff (rst)
    !exValid |-> !(exPcSrc || exRegWrite || exMemWrite))
    else $error("bubble carries write or pc control");

endmodule

// ==== src/ControlUnit.sv ====
`timescale 1ns/1ps
`include "riscvControl_macros.svh"

module ControlUnit
  import ControlTypesPkg::*;
(
  input  logic               clk,
  input  logic               rst,
  input  logic               instrValid,
  input  logic [`XLEN-1:0]   instr,
  input  logic               zero,
  output logic               exValid,
  output logic               exIllegal,
  output MemControlT         exMemControl,
  output logic               exResultSrc,
  output logic               exPcSrc,
  output logic               exAluSrc,
  output logic               exRegWrite,
  output logic               exMemWrite,
  output AluOpT              exAluOp,
  output logic [`XLEN-1:0]   exImm
);

  // decode side, all combinational
  InstructionTypes    instrType;
  InstructionSubTypes instrSubType;
  logic               illegal;
  MemControlT         memControl;
  logic               resultSrc;
  logic               pcSrc;
  logic               aluSrc;
  logic               regWrite;
  logic               memWrite;
  AluOpT              aluOp;
  logic [`XLEN-1:0]   imm;

  // raw word maps straight onto the format union
  InstructionClassifier u_classifier (
    .instr        (instr),
    .instrType    (instrType),
    .instrSubType (instrSubType),
    .illegal      (illegal)
  );

  // zero belongs to the word presented this cycle
  ControlDecode u_controlDecode (
    .instrType    (instrType),
    .instrSubType (instrSubType),
    .zero         (zero),
    .memControl   (memControl),
    .resultSrc    (resultSrc),
    .pcSrc        (pcSrc),
    .aluSrc       (aluSrc),
    .regWrite     (regWrite),
    .memWrite     (memWrite)
  );

  AluControlDecode u_aluControlDecode (
    .instrType (instrType),
    .instr     (instr),
    .aluOp     (aluOp)
  );

  ImmediateGenerator u_immGen (
    .instr (instr),
    .imm   (imm)
  );

  // single clock of latency, squash and illegal handling
  DecodeExecuteRegister u_decodeExecute (
    .clk          (clk),
    .rst          (rst),
    .instrValid   (instrValid),
    .illegal      (illegal),
    .memControl   (memControl),
    .resultSrc    (resultSrc),
    .pcSrc        (pcSrc),
    .aluSrc       (aluSrc),
    .regWrite     (regWrite),
    .memWrite     (memWrite),
    .aluOp        (aluOp),
    .imm          (imm),
    .exValid      (exValid),
    .exIllegal    (exIllegal),
    .exMemControl (exMemControl),
    .exResultSrc  (exResultSrc),
    .exPcSrc      (exPcSrc),
    .exAluSrc     (exAluSrc),
    .exRegWrite   (exRegWrite),
    .exMemWrite   (exMemWrite),
    .exAluOp      (exAluOp),
    .exImm        (exImm)
  );

endmodule

// ==== verif/ControlUnitTb.sv ====
`timescale 1ns/1ps
`include "riscvControl_macros.svh"

module ControlUnitTb
  import InstrFormatPkg::*;
  import ControlTypesPkg::*;
();

  localparam int NUM_CYCLES    = 3000;
  localparam int RESET_TIMEOUT = 100;

  // dut ports
  logic             clk;
  logic             rst;
  logic             instrValid;
  logic [`XLEN-1:0] instr;
  logic             zero;
  logic             exValid;
  logic             exIllegal;
  MemControlT       exMemControl;
  logic             exResultSrc;
  logic             exPcSrc;
  logic             exAluSrc;
  logic             exRegWrite;
  logic             exMemWrite;
  AluOpT            exAluOp;
  logic [`XLEN-1:0] exImm;

  // expected decode-to-execute stage
  logic             expValid;
  logic             expIllegal;
  MemControlT       expMemControl;
  logic             expResultSrc;
  logic             expPcSrc;
  logic             expAluSrc;
  logic             expRegWrite;
  logic             expMemWrite;
  AluOpT            expAluOp;
  logic [`XLEN-1:0] expImm;

  // model results for one word
  logic             mLegal;
  MemControlT       mMemControl;
  logic             mResultSrc;
  logic             mPcSrc;
  logic             mAluSrc;
  logic             mRegWrite;
  logic             mMemWrite;
  AluOpT            mAluOp;
  logic [`XLEN-1:0] mImm;
  logic             squash;

  // last drive, captured by the dut on the next edge
  logic             prevValid;
  logic [`XLEN-1:0] prevWord;
  logic             prevZero;

  logic [31:0]      rndPick;
  logic [31:0]      rndFields;
  logic [31:0]      rndCtl;
  logic [`XLEN-1:0] nextWord;
  integer           seed;
  int               errorCount;
  int               checkCount;
  int               squashCount;
  int               waitCount;
  int               cycle;
  logic             timedOut;

  ControlUnit u_dut (
    .clk          (clk),
    .rst          (rst),
    .instrValid   (instrValid),
    .instr        (instr),
    .zero         (zero),
    .exValid      (exValid),
    .exIllegal    (exIllegal),
    .exMemControl (exMemControl),
    .exResultSrc  (exResultSrc),
    .exPcSrc      (exPcSrc),
    .exAluSrc     (exAluSrc),
    .exRegWrite   (exRegWrite),
    .exMemWrite   (exMemWrite),
    .exAluOp      (exAluOp),
    .exImm        (exImm)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // 16 cycles of reset
  initial begin
    rst = 1'b1;
    repeat (16) @(posedge clk);
    rst <= 1'b0;
  end

  task automatic checkBit(input string name, input logic expected, input logic actual);
    checkCount++;
    assert (actual === expected) else begin
      errorCount++;
      $display("ERR %0t %s expected %b actual %b", $time, name, expected, actual);
    end
  endtask

  task automatic checkWord(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
    checkCount++;
    assert (actual === expected) else begin
      errorCount++;
      $display("ERR %0t %s expected %h actual %h", $time, name, expected, actual);
    end
  endtask

  // rv32i funct3 table, bit 30 picks sub only for register ops
  function automatic AluOpT aluFromFunct(input logic [2:0] funct3, input logic bit30,
                                         input logic isReg);
    case (funct3)
      3'b000:  return (isReg && bit30) ? ALU_SUB : ALU_ADD;
      3'b001:  return ALU_SLL;
      3'b010:  return ALU_SLT;
      3'b011:  return ALU_SLTU;
      3'b100:  return ALU_XOR;
      3'b101:  return bit30 ? ALU_SRA : ALU_SRL;
      3'b110:  return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  // reference decode straight from the isa bit positions
  task automatic decodeModel(
    input  logic [31:0] word,
    input  logic        zeroIn,
    output logic        legal,
    output MemControlT  memCtl,
    output logic        resSrc,
    output logic        pcSel,
    output logic        immSel,
    output logic        regWr,
    output logic        memWr,
    output AluOpT       op,
    output logic [31:0] immVal
  );
    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic [31:0] immI;
    logic [31:0] immS;
    logic [31:0] immB;
    logic [31:0] immU;
    logic [31:0] immJ;
    opcode = word[6:0];
    funct3 = word[14:12];
    immI   = {{20{word[31]}}, word[31:20]};
    immS   = {{20{word[31]}}, word[31:25], word[11:7]};
    immB   = {{19{word[31]}}, word[31], word[7], word[30:25], word[11:8], 1'b0};
    immU   = {word[31:12], 12'b0};
    immJ   = {{11{word[31]}}, word[31], word[19:12], word[20], word[30:21], 1'b0};
    legal  = 1'b1;
    memCtl = MEM_NONE;
    resSrc = 1'b0;
    pcSel  = 1'b0;
    immSel = 1'b0;
    regWr  = 1'b0;
    memWr  = 1'b0;
    op     = ALU_ADD;
    immVal = 32'd0;
    case (opcode)
      OPC_OP: begin
        regWr = 1'b1;
        op    = aluFromFunct(funct3, word[30], 1'b1);
      end
      OPC_OP_IMM: begin
        regWr  = 1'b1;
        immSel = 1'b1;
        op     = aluFromFunct(funct3, word[30], 1'b0);
        immVal = immI;
      end
      OPC_LOAD: begin
        regWr  = 1'b1;
        immSel = 1'b1;
        immVal = immI;
        case (funct3)
          3'b000:  memCtl = MEM_LB;
          3'b001:  memCtl = MEM_LH;
          3'b010:  memCtl = MEM_LW;
          3'b100:  memCtl = MEM_LBU;
          3'b101:  memCtl = MEM_LHU;
          default: legal = 1'b0;
        endcase
      end
      OPC_STORE: begin
        memWr  = 1'b1;
        immSel = 1'b1;
        immVal = immS;
        case (funct3)
          3'b000:  memCtl = MEM_SB;
          3'b001:  memCtl = MEM_SH;
          3'b010:  memCtl = MEM_SW;
          default: legal = 1'b0;
        endcase
      end
      OPC_BRANCH: begin
        op     = ALU_SUB;
        immVal = immB;
        // only beq and bne resolve, ordered compares never taken
        case (funct3)
          3'b000:                         pcSel = zeroIn;
          3'b001:                         pcSel = !zeroIn;
          3'b100, 3'b101, 3'b110, 3'b111: pcSel = 1'b0;
          default:                        legal = 1'b0;
        endcase
      end
      OPC_JAL, OPC_JALR: begin
        pcSel  = 1'b1;
        regWr  = 1'b1;
        resSrc = 1'b1;
        immSel = 1'b1;
        immVal = (opcode == OPC_JAL) ? immJ : immI;
        if (opcode == OPC_JALR && funct3 != 3'b000) begin
          legal = 1'b0;
        end
      end
      OPC_LUI: begin
        regWr  = 1'b1;
        immSel = 1'b1;
        op     = ALU_PASSB;
        immVal = immU;
      end
      OPC_AUIPC: begin
        regWr  = 1'b1;
        resSrc = 1'b1;
        immVal = immU;
      end
      default: legal = 1'b0;
    endcase
  endtask

  // opcode from the legal set, other fields straight from random bits
  function automatic logic [31:0] makeInstr(input logic [31:0] pick, input logic [31:0] fields);
    logic [6:0] opc;
    case (pick % 32'd9)
      32'd0:   opc = OPC_OP;
      32'd1:   opc = OPC_OP_IMM;
      32'd2:   opc = OPC_LOAD;
      32'd3:   opc = OPC_STORE;
      32'd4:   opc = OPC_BRANCH;
      32'd5:   opc = OPC_JAL;
      32'd6:   opc = OPC_JALR;
      32'd7:   opc = OPC_LUI;
      default: opc = OPC_AUIPC;
    endcase
    return {fields[31:7], opc};
  endfunction

  task automatic compareStage();
    checkBit("exValid", expValid, exValid);
    checkBit("exIllegal", expIllegal, exIllegal);
    checkWord("exMemControl", 32'(expMemControl), 32'(exMemControl));
    checkBit("exResultSrc", expResultSrc, exResultSrc);
    checkBit("exPcSrc", expPcSrc, exPcSrc);
    checkBit("exAluSrc", expAluSrc, exAluSrc);
    checkBit("exRegWrite", expRegWrite, exRegWrite);
    checkBit("exMemWrite", expMemWrite, exMemWrite);
    // operands only matter for a live slot
    if (expValid) begin
      checkWord("exAluOp", 32'(expAluOp), 32'(exAluOp));
      checkWord("exImm", expImm, exImm);
    end
  endtask

  initial begin
    instrValid    = 1'b0;
    instr         = '0;
    zero          = 1'b0;
    seed          = 32'h1c70_8629;
    errorCount    = 0;
    checkCount    = 0;
    squashCount   = 0;
    timedOut      = 1'b0;
    expValid      = 1'b0;
    expIllegal    = 1'b0;
    expMemControl = MEM_NONE;
    expResultSrc  = 1'b0;
    expPcSrc      = 1'b0;
    expAluSrc     = 1'b0;
    expRegWrite   = 1'b0;
    expMemWrite   = 1'b0;
    expAluOp      = ALU_ADD;
    expImm        = '0;
    prevValid     = 1'b0;
    prevWord      = '0;
    prevZero      = 1'b0;

    waitCount = 0;
    while (rst !== 1'b0 && waitCount < RESET_TIMEOUT) begin
      @(negedge clk);
      waitCount++;
    end
    if (rst !== 1'b0) begin
      $display("reset was not released within %0d cycles", RESET_TIMEOUT);
      timedOut = 1'b1;
    end

    if (!timedOut) begin
      // stage still empty right after reset
      checkBit("exValid", 1'b0, exValid);
      checkBit("exRegWrite", 1'b0, exRegWrite);
      checkBit("exMemWrite", 1'b0, exMemWrite);
      checkBit("exPcSrc", 1'b0, exPcSrc);
      checkWord("exMemControl", 32'(MEM_NONE), 32'(exMemControl));

      for (cycle = 0; cycle < NUM_CYCLES; cycle++) begin
        @(posedge clk);
        // dut takes the previous drive on this edge
        decodeModel(prevWord, prevZero, mLegal, mMemControl, mResultSrc, mPcSrc,
                    mAluSrc, mRegWrite, mMemWrite, mAluOp, mImm);
        squash = expValid && expPcSrc;
        if (squash && prevValid) begin
          squashCount++;
        end
        expIllegal = prevValid && !mLegal && !squash;
        expValid   = prevValid && mLegal && !squash;
        expAluOp   = mAluOp;
        expImm     = mImm;
        if (expValid) begin
          expMemControl = mMemControl;
          expResultSrc  = mResultSrc;
          expPcSrc      = mPcSrc;
          expAluSrc     = mAluSrc;
          expRegWrite   = mRegWrite;
          expMemWrite   = mMemWrite;
        end else begin
          expMemControl = MEM_NONE;
          expResultSrc  = 1'b0;
          expPcSrc      = 1'b0;
          expAluSrc     = 1'b0;
          expRegWrite   = 1'b0;
          expMemWrite   = 1'b0;
        end

        rndPick   = $random(seed);
        rndFields = $random(seed);
        rndCtl    = $random(seed);
        // about one in ten is a raw garbage word
        if ((rndCtl % 32'd10) == 32'd0) begin
          nextWord = rndFields;
        end else begin
          nextWord = makeInstr(rndPick, rndFields);
        end
        prevWord  = nextWord;
        prevValid = (rndCtl[10:8] != 3'd0);
        prevZero  = rndCtl[12];
        instrValid <= prevValid;
        instr      <= prevWord;
        zero       <= prevZero;

        @(negedge clk);
        compareStage();
      end
    end

    $display("cycles %0d checks %0d errors %0d squashed %0d",
             cycle, checkCount, errorCount, squashCount);
    if (errorCount == 0 && !timedOut) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== riscvControl.f ====
+incdir+include
src/InstrFormatPkg.sv
src/ControlTypesPkg.sv
src/InstructionClassifier.sv
src/ControlDecode.sv
src/AluControlDecode.sv
src/ImmediateGenerator.sv
src/DecodeExecuteRegister.sv
src/ControlUnit.sv
verif/ControlUnitTb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the control unit testbench with verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -rf obj_dir "$LOG"

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f riscvControl.f --top-module ControlUnitTb -o ControlUnitTb
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/ControlUnitTb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^TEST PASSED$" "$LOG"; then
  exit 0
fi
echo "pass line not found in $LOG"
exit 1
